// ==== sources.f ====
adc_ctrl_pkg.sv
adc_cmd_queue.sv
adc_sequencer.sv
spi_frame_engine.sv
adc_sample_packer.sv
ads816x_ctrl.sv
tb_adc_model.sv
tb_ads816x_ctrl.sv

// ==== Bender.yml ====
package:
  name: ads816x_ctrl

sources:
  - adc_ctrl_pkg.sv
  - adc_cmd_queue.sv
  - adc_sequencer.sv
  - spi_frame_engine.sv
  - adc_sample_packer.sv
  - ads816x_ctrl.sv
  - target: simulation
    files:
      - tb_adc_model.sv
      - tb_ads816x_ctrl.sv

// ==== tb_ads816x_ctrl.sv ====
`timescale 1ns/1ps

module tb_ads816x_ctrl import adc_ctrl_pkg::*; ();

  localparam int NUM_ROUNDS      = 12;
  localparam int RESET_CYCLES    = 8;
  localparam int TIMEOUT_PER_CMD = 400;
  localparam int TIMEOUT_BASE    = 1000;

  // DUT ports
  logic             clk = 1'b0;
  logic             resetn;
  logic             cmd_valid;
  logic [CMD_W-1:0] cmd_word;
  logic             cmd_credit;
  logic             data_valid;
  logic [CMD_W-1:0] data_word;
  logic             data_credit;
  logic             trigger;
  logic             waiting_for_trig;
  logic             n_cs;
  logic             mosi;
  logic             miso;
  logic             cmd_underflow;
  logic             data_overflow;
  logic             unexp_trig;
  logic             delay_too_short;
  logic             bad_cmd;

  // Host side bookkeeping
  int               seed = 32'h5e80_be1d;
  logic [CMD_W-1:0] cmd_pending [$];   // Waiting for a credit
  logic [CMD_W-1:0] exp_words [$];     // Reference model output
  logic [CMD_W-1:0] exp_word;
  logic             in_reset = 1'b1;
  logic             check_data = 1'b0;
  logic             hold_credits = 1'b0;
  int               host_credits = CMD_DEPTH;
  int               owed = 0;          // Data credits not yet returned
  int               credit_wait = 0;
  int               low_cnt = 0;
  int               cmds_sent = 0;
  int               credits_back = 0;
  int               words_rcvd = 0;
  int               words_expected = 0;
  int               frame_base = 0;    // Model request number of the next frame
  int               errors = 0;
  int               model_errors;
  int               cycles = 0;
  int               kind;

  ads816x_ctrl ads816x_ctrl_i (.*);

  tb_adc_model adc_i (
    .clk        (clk),
    .resetn     (resetn),
    .n_cs       (n_cs),
    .mosi       (mosi),
    .miso       (miso),
    .bad_frames (model_errors)
  );

  always #4 clk = ~clk;   // 8 ns period

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Model answer for a request of channel ch in request slot n
  function automatic logic [SAMPLE_W-1:0] model_sample(input logic [CH_W-1:0] ch, input int n);
    return {ch, (SAMPLE_W-CH_W)'(n)};
  endfunction

  function automatic logic [4:0] err_flags();
    return {cmd_underflow, data_overflow, unexp_trig, delay_too_short, bad_cmd};
  endfunction

  function automatic logic [CMD_W-1:0] make_cmd(input cmd_op_e op, input logic [COUNT_W-1:0] arg);
    logic [CMD_W-1:0] w;
    w                   = '0;
    w[CMD_W-1:OP_LSB]   = op;
    w[COUNT_W-1:0]      = arg;
    return w;
  endfunction

  task automatic finish_run();
    $display("Run complete: %0d errors, %0d model errors, %0d commands, %0d data words",
             errors, model_errors, cmds_sent, words_rcvd);
    if (errors == 0 && model_errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    in_reset = 1'b1;                   // Host side clears on the next falling edge
    @(negedge clk);
    resetn  = 1'b0;
    trigger = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    resetn = 1'b1;
    @(posedge clk);
    in_reset   = 1'b0;
    frame_base = 0;
  endtask

  // Until every queued command is sent and every expected word is in
  task automatic wait_done();
    @(posedge clk);
    while (cmd_pending.size() != 0 || exp_words.size() != 0)
      @(posedge clk);
  endtask

  task automatic run_order_read();
    logic [CH_W-1:0]     order [NUM_CH];
    logic [CMD_W-1:0]    w;
    logic [SAMPLE_W-1:0] lo;
    logic [SAMPLE_W-1:0] hi;
    w = make_cmd(OP_SET_ORD, '0);
    w[CONT_BIT] = 1'b1;                // Read must follow at once
    for (int i = 0; i < NUM_CH; i++) begin
      order[i]               = $random(seed);
      w[i*CH_W +: CH_W]      = order[i];
    end
    cmd_pending.push_back(w);
    cmd_pending.push_back(make_cmd(OP_ADC_RD, COUNT_W'(300 + ($random(seed) & 255))));
    for (int i = 0; i < NUM_CH; i += 2) begin
      lo = model_sample(order[i], frame_base + i);
      hi = model_sample(order[i+1], frame_base + i + 1);
      exp_words.push_back({hi, lo});   // Later sample high
      words_expected++;
    end
    frame_base += NUM_CH + 1;          // Eight reads and the dummy frame
    wait_done();
  endtask

  task automatic run_single_read();
    logic [CH_W-1:0] ch;
    ch = $random(seed);
    cmd_pending.push_back(make_cmd(OP_ADC_RD_CH, COUNT_W'(ch)));
    exp_words.push_back({{(CMD_W-SAMPLE_W){1'b0}}, model_sample(ch, frame_base)});
    words_expected++;
    frame_base += 2;
    wait_done();
  endtask

  task automatic run_trigger_wait();
    logic [CMD_W-1:0] w;
    int               n;
    int               gaps [4];
    n = 1 + ($random(seed) & 3);
    for (int i = 0; i < 4; i++)
      gaps[i] = 1 + ($random(seed) & 7);
    w = make_cmd(OP_NO_OP, COUNT_W'(n));
    w[TRIG_BIT] = 1'b1;
    cmd_pending.push_back(w);
    @(negedge clk);
    while (!waiting_for_trig)
      @(negedge clk);
    for (int i = 0; i < n; i++) begin
      repeat (gaps[i]) @(negedge clk);
      if (waiting_for_trig !== 1'b1) begin
        $display("[ERROR] %0t waiting_for_trig got %b expected 1", $time, waiting_for_trig);
        errors++;
      end
      trigger = 1'b1;                  // One-cycle pulse
      @(negedge clk);
      trigger = 1'b0;
      if (waiting_for_trig !== (i < n - 1)) begin
        $display("[ERROR] %0t waiting_for_trig got %b expected %b",
                 $time, waiting_for_trig, i < n - 1);
        errors++;
      end
    end
    wait_done();
  endtask

  // Wait for the flag, let a frame in flight end, then n_cs must stay high
  task automatic expect_error(input logic [4:0] mask);
    int low_seen;
    low_seen = 0;
    @(negedge clk);
    while ((err_flags() & mask) == '0)
      @(negedge clk);
    repeat (CS_HIGH_CYCLES + SAMPLE_W) @(negedge clk);
    if (err_flags() !== mask) begin
      $display("[ERROR] %0t error_flags got %b expected %b", $time, err_flags(), mask);
      errors++;
    end
    repeat (64) begin
      if (n_cs !== 1'b1)
        low_seen++;
      @(negedge clk);
    end
    if (low_seen != 0) begin
      $display("[ERROR] %0t n_cs got 0 expected 1 for %0d cycles in error state",
               $time, low_seen);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Host side, all driven on the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    cmd_valid   = 1'b0;
    data_credit = 1'b0;
    if (in_reset) begin
      cmd_pending.delete();
      exp_words.delete();
      host_credits = CMD_DEPTH;
      owed         = 0;
      credit_wait  = 0;
      low_cnt      = 0;
    end else begin
      if (cmd_credit) begin
        host_credits++;
        credits_back++;
        if (host_credits > CMD_DEPTH) begin
          $display("Command credit returned at %0t with no command outstanding", $time);
          errors++;
        end
      end
      if (cmd_pending.size() != 0 && host_credits > 0) begin
        cmd_word  = cmd_pending.pop_front();
        cmd_valid = 1'b1;
        host_credits--;
        cmds_sent++;
      end
      if (data_valid) begin
        words_rcvd++;
        owed++;
        if (check_data) begin
          if (exp_words.size() == 0) begin
            $display("Unexpected data word %h at %0t", data_word, $time);
            errors++;
          end else begin
            exp_word = exp_words.pop_front();
            if (data_word !== exp_word) begin
              $display("[ERROR] %0t data_word got %h expected %h", $time, data_word, exp_word);
              errors++;
            end
          end
        end
      end
      // Credits go back after a random short delay
      if (owed > 0 && !hold_credits) begin
        if (credit_wait == 0) begin
          data_credit = 1'b1;
          owed--;
          credit_wait = $random(seed) & 7;
        end else begin
          credit_wait--;
        end
      end
      if (!n_cs) begin
        low_cnt++;
      end else begin
        if (low_cnt != 0 && low_cnt != SAMPLE_W) begin
          $display("[ERROR] %0t n_cs low run got %0d expected %0d", $time, low_cnt, SAMPLE_W);
          errors++;
        end
        low_cnt = 0;
      end
    end
  end

  // Cycle limit grows with the commands sent
  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_BASE + TIMEOUT_PER_CMD * cmds_sent) begin
      $display("Timeout after %0d cycles with %0d commands sent", cycles, cmds_sent);
      errors++;
      finish_run();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    resetn      = 1'b0;
    cmd_valid   = 1'b0;
    cmd_word    = '0;
    data_credit = 1'b0;
    trigger     = 1'b0;
    apply_reset();
    check_data = 1'b1;
    for (int r = 0; r < NUM_ROUNDS; r++) begin
      @(posedge clk);
      kind = (r < 3) ? r : $unsigned($random(seed)) % 3;   // Each kind at least once
      case (kind)
        0:       run_order_read();
        1:       run_single_read();
        default: run_trigger_wait();
      endcase
    end
    repeat (CS_HIGH_CYCLES + SAMPLE_W) @(negedge clk);
    @(posedge clk);
    if (credits_back != cmds_sent) begin
      $display("[ERROR] %0t cmd_credit count got %0d expected %0d", $time, credits_back, cmds_sent);
      errors++;
    end
    if (words_rcvd != words_expected) begin
      $display("[ERROR] %0t data word count got %0d expected %0d",
               $time, words_rcvd, words_expected);
      errors++;
    end
    if (err_flags() !== '0) begin
      $display("[ERROR] %0t error_flags got %b expected 00000", $time, err_flags());
      errors++;
    end

    // Error cases, each from a fresh reset
    apply_reset();
    check_data = 1'b0;
    cmd_pending.push_back({3'd5, {(CMD_W-3){1'b0}}});
    expect_error(5'b00001);            // bad_cmd
    apply_reset();
    cmd_pending.push_back(make_cmd(OP_ADC_RD, COUNT_W'(100)));
    expect_error(5'b00010);            // delay_too_short
    apply_reset();
    @(negedge clk);
    trigger = 1'b1;
    @(negedge clk);
    trigger = 1'b0;
    expect_error(5'b00100);            // unexp_trig
    apply_reset();
    cmd_pending.push_back(make_cmd(OP_NO_OP, '0) | (CMD_W'(1) << CONT_BIT));
    expect_error(5'b10000);            // cmd_underflow
    apply_reset();
    hold_credits = 1'b1;               // Five words against four credits
    cmd_pending.push_back(make_cmd(OP_ADC_RD, COUNT_W'(400)));
    cmd_pending.push_back(make_cmd(OP_ADC_RD_CH, '0));
    expect_error(5'b01000);            // data_overflow
    @(posedge clk);
    hold_credits = 1'b0;
    finish_run();
  end

endmodule

// ==== tb_adc_model.sv ====
`timescale 1ns/1ps

module tb_adc_model import adc_ctrl_pkg::*; (
  input  logic clk,
  input  logic resetn,
  input  logic n_cs,
  input  logic mosi,
  output logic miso,
  output int   bad_frames       // Malformed request frames seen
);

  logic [SAMPLE_W-1:0]       rx_frame;    // Request shifted in from mosi
  logic [SAMPLE_W-1:0]       tx_frame;    // Answer for the frame on the wire
  logic [SAMPLE_W-CH_W-1:0]  frame_cnt;   // Running request number
  int                        bit_idx;
  logic                      in_rst = 1'b1;

  initial begin
    bad_frames = 0;
    miso       = 1'b0;
  end

  // Reset taken on the rising edge, resetn moves on the falling one
  always @(posedge clk)
    in_rst <= !resetn;

  //////////////////////////////////////////////////////////////////////
  // Frame handling on the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (in_rst) begin
      rx_frame  = '0;
      tx_frame  = '0;
      frame_cnt = '0;
      bit_idx   = 0;
      miso      = 1'b0;
    end else if (!n_cs) begin
      if (bit_idx < SAMPLE_W)
        miso = tx_frame[SAMPLE_W-1-bit_idx];        // MSB first
      rx_frame = {rx_frame[SAMPLE_W-2:0], mosi};
      bit_idx++;
    end else if (bit_idx != 0) begin
      // n_cs back high, decode the request just taken in
      if (bit_idx != SAMPLE_W || rx_frame[SAMPLE_W-1 -: 2] != OTF_REQ_PREFIX
          || rx_frame[OTF_PAD_W-1:0] != '0) begin
        $display("ADC model at %0t: malformed request frame %h after %0d bits",
                 $time, rx_frame, bit_idx);
        bad_frames++;
      end
      tx_frame  = {rx_frame[SAMPLE_W-3 -: CH_W], frame_cnt};   // Sent one frame later
      frame_cnt = frame_cnt + 1'b1;
      bit_idx   = 0;
    end
  end

endmodule

// ==== ads816x_ctrl.sv ====
`timescale 1ns/1ps

module ads816x_ctrl import adc_ctrl_pkg::*; (
  input  logic             clk,
  input  logic             resetn,
  // Host command side
  input  logic             cmd_valid,
  input  logic [CMD_W-1:0] cmd_word,
  output logic             cmd_credit,
  // Host data side
  output logic             data_valid,
  output logic [CMD_W-1:0] data_word,
  input  logic             data_credit,
  // Trigger
  input  logic             trigger,
  output logic             waiting_for_trig,
  // ADC SPI
  output logic             n_cs,
  output logic             mosi,
  input  logic             miso,
  // Sticky errors
  output logic             cmd_underflow,
  output logic             data_overflow,
  output logic             unexp_trig,
  output logic             delay_too_short,
  output logic             bad_cmd
);

  logic [CMD_W-1:0]    q_word;
  logic                q_valid;
  logic                q_pop;
  logic                frame_start;
  logic [CH_W-1:0]     frame_ch;
  logic                frame_done;
  logic                rx_valid;
  logic [SAMPLE_W-1:0] rx_word;
  logic                sample_valid;
  logic [SAMPLE_W-1:0] sample_word;
  logic                sample_single;

  //////////////////////////////////////////////////////////////////////
  // Queue, sequencer, SPI engine, packer
  //////////////////////////////////////////////////////////////////////

  adc_cmd_queue queue_i (
    .clk        (clk),
    .resetn     (resetn),
    .cmd_valid  (cmd_valid),
    .cmd_word   (cmd_word),
    .q_pop      (q_pop),
    .q_word     (q_word),
    .q_valid    (q_valid),
    .cmd_credit (cmd_credit)
  );

  adc_sequencer seq_i (
    .clk              (clk),
    .resetn           (resetn),
    .q_word           (q_word),
    .q_valid          (q_valid),
    .q_pop            (q_pop),
    .trigger          (trigger),
    .waiting_for_trig (waiting_for_trig),
    .frame_start      (frame_start),
    .frame_ch         (frame_ch),
    .frame_done       (frame_done),
    .rx_valid         (rx_valid),
    .rx_word          (rx_word),
    .sample_valid     (sample_valid),
    .sample_word      (sample_word),
    .sample_single    (sample_single),
    .data_overflow    (data_overflow),   // Packer overflow stops the sequencer
    .cmd_underflow    (cmd_underflow),
    .unexp_trig       (unexp_trig),
    .delay_too_short  (delay_too_short),
    .bad_cmd          (bad_cmd)
  );

  spi_frame_engine spi_i (
    .clk         (clk),
    .resetn      (resetn),
    .frame_start (frame_start),
    .frame_ch    (frame_ch),
    .frame_done  (frame_done),
    .rx_valid    (rx_valid),
    .rx_word     (rx_word),
    .n_cs        (n_cs),
    .mosi        (mosi),
    .miso        (miso)
  );

  adc_sample_packer pack_i (
    .clk           (clk),
    .resetn        (resetn),
    .sample_valid  (sample_valid),
    .sample_word   (sample_word),
    .sample_single (sample_single),
    .data_credit   (data_credit),
    .data_valid    (data_valid),
    .data_word     (data_word),
    .data_overflow (data_overflow)
  );

endmodule

// ==== adc_sample_packer.sv ====
`timescale 1ns/1ps

module adc_sample_packer import adc_ctrl_pkg::*; (
  input  logic                clk,
  input  logic                resetn,
  input  logic                sample_valid,
  input  logic [SAMPLE_W-1:0] sample_word,
  input  logic                sample_single,   // Emit alone, zero upper half
  input  logic                data_credit,     // Host returns one credit
  output logic                data_valid,
  output logic [CMD_W-1:0]    data_word,
  output logic                data_overflow
);

  logic [SAMPLE_W-1:0] first_sample;   // Earlier half of a pair
  logic                have_first;
  logic [CRED_W-1:0]   credits;
  logic                word_ready;
  logic                send;

  assign word_ready = sample_valid && (sample_single || have_first);
  assign send       = word_ready && (credits != '0);

  // Pair tracking
  always_ff @(posedge clk) begin
    if (!resetn)
      have_first <= 1'b0;
    else if (sample_valid && !sample_single)
      have_first <= !have_first;
  end

  always_ff @(posedge clk) begin
    if (sample_valid && !sample_single && !have_first)
      first_sample <= sample_word;
  end

  //////////////////////////////////////////////////////////////////////
  // Output word and credits
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn)
      data_valid <= 1'b0;
    else
      data_valid <= send;
  end

  // Later sample high, earlier low
  always_ff @(posedge clk) begin
    if (send)
      data_word <= sample_single ? {{(CMD_W-SAMPLE_W){1'b0}}, sample_word}
                                 : {sample_word, first_sample};
  end

  always_ff @(posedge clk) begin
    if (!resetn)
      credits <= CRED_W'(DATA_CREDITS);
    else if (send && !data_credit)
      credits <= credits - 1'b1;
    else if (data_credit && !send)
      credits <= credits + 1'b1;   // Both at once cancel out
  end

  // Dropped word is sticky
  always_ff @(posedge clk) begin
    if (!resetn)
      data_overflow <= 1'b0;
    else if (word_ready && credits == '0)
      data_overflow <= 1'b1;
  end

  // Host never returns more than it received
  a_credit_bound: assert property (@(posedge clk) disable iff (!resetn)
    data_credit |-> (credits < DATA_CREDITS) || send);

endmodule

// ==== spi_frame_engine.sv ====
`timescale 1ns/1ps

module spi_frame_engine import adc_ctrl_pkg::*; (
  input  logic                clk,
  input  logic                resetn,
  input  logic                frame_start,
  input  logic [CH_W-1:0]     frame_ch,
  output logic                frame_done,
  output logic                rx_valid,
  output logic [SAMPLE_W-1:0] rx_word,
  output logic                n_cs,
  output logic                mosi,
  input  logic                miso
);

  logic [CS_CNT_W-1:0]         cs_timer;   // Counts the n_cs high gap
  logic [$clog2(SAMPLE_W)-1:0] bit_cnt;    // Bits left while n_cs is low
  logic [SAMPLE_W-1:0]         mosi_sr;
  logic [SAMPLE_W-1:0]         miso_sr;
  logic                        cs_expire;
  logic                        last_bit;

  assign cs_expire = (cs_timer == CS_CNT_W'(1));
  assign last_bit  = !n_cs && (bit_cnt == '0);

  //////////////////////////////////////////////////////////////////////
  // Chip select and bit timing
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn)
      cs_timer <= '0;
    else if (frame_start)
      cs_timer <= CS_CNT_W'(CS_HIGH_CYCLES - 1);   // Start cycle counts as the first
    else if (cs_timer != '0)
      cs_timer <= cs_timer - 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      n_cs       <= 1'b1;
      bit_cnt    <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= last_bit;   // Lands with n_cs back high
      if (cs_expire) begin
        n_cs    <= 1'b0;
        bit_cnt <= '1;
      end else if (last_bit) begin
        n_cs <= 1'b1;
      end else if (!n_cs) begin
        bit_cnt <= bit_cnt - 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Data shift, MSB first
  //////////////////////////////////////////////////////////////////////

  // Request word loaded during the high gap
  always_ff @(posedge clk) begin
    if (!resetn)
      mosi_sr <= '0;
    else if (frame_start)
      mosi_sr <= {OTF_REQ_PREFIX, frame_ch, {OTF_PAD_W{1'b0}}};
    else if (!n_cs)
      mosi_sr <= {mosi_sr[SAMPLE_W-2:0], 1'b0};
  end

  assign mosi = mosi_sr[SAMPLE_W-1];

  // One miso bit per low cycle
  always_ff @(posedge clk) begin
    if (!n_cs)
      miso_sr <= {miso_sr[SAMPLE_W-2:0], miso};
  end

  assign rx_word  = miso_sr;      // Complete in the frame_done cycle
  assign rx_valid = frame_done;

  a_cs_low_len: assert property (@(posedge clk) disable iff (!resetn)
    $fell(n_cs) |-> (!n_cs) [*SAMPLE_W] ##1 n_cs);

endmodule

// ==== adc_sequencer.sv ====
`timescale 1ns/1ps

module adc_sequencer import adc_ctrl_pkg::*; (
  input  logic                clk,
  input  logic                resetn,
  // Command queue
  input  logic [CMD_W-1:0]    q_word,
  input  logic                q_valid,
  output logic                q_pop,
  // Trigger
  input  logic                trigger,
  output logic                waiting_for_trig,
  // SPI frame engine
  output logic                frame_start,
  output logic [CH_W-1:0]     frame_ch,
  input  logic                frame_done,
  input  logic                rx_valid,
  input  logic [SAMPLE_W-1:0] rx_word,
  // Sample packer
  output logic                sample_valid,
  output logic [SAMPLE_W-1:0] sample_word,
  output logic                sample_single,
  input  logic                data_overflow,
  // Sticky error flags
  output logic                cmd_underflow,
  output logic                unexp_trig,
  output logic                delay_too_short,
  output logic                bad_cmd
);

  seq_state_e         state;
  cmd_op_e            cmd_op;
  logic               op_known;
  logic               cmd_done;
  logic               do_next;
  logic               timed_cmd;
  logic               start_read;
  logic               next_frame;
  logic               read_end;
  logic               delay_done;
  logic               trig_done;
  logic               set_underflow;
  logic               set_unexp;
  logic               set_short;
  logic               set_bad;
  logic               err_now;
  logic               wait_trig;     // Latched TRIG_BIT of the running command
  logic               expect_next;   // Latched CONT_BIT
  logic               rd_single;
  logic               in_flight;
  logic [COUNT_W-1:0] delay_timer;
  logic [COUNT_W-1:0] trig_cnt;
  logic [CH_W-1:0]    sample_order [NUM_CH];
  logic [CH_W:0]      frame_idx;     // Frame now on the wire
  logic [CH_W:0]      nxt_idx;
  logic [CH_W:0]      last_idx;

  //////////////////////////////////////////////////////////////////////
  // Decode and command handoff
  //////////////////////////////////////////////////////////////////////

  assign cmd_op    = cmd_op_e'(q_word[CMD_W-1:OP_LSB]);
  assign op_known  = cmd_op inside {OP_NO_OP, OP_SET_ORD, OP_ADC_RD, OP_ADC_RD_CH};
  assign delay_done = (delay_timer == '0);
  assign trig_done  = (trig_cnt == '0) || (trigger && trig_cnt == COUNT_W'(1)); // Zero ends at once
  assign read_end   = (state == S_READ_WAIT) && frame_done;

  // Running command is finished and the next may start
  always_comb begin
    case (state)
      S_IDLE:      cmd_done = 1'b1;
      S_DELAY:     cmd_done = delay_done;
      S_TRIG_WAIT: cmd_done = trig_done;
      S_READ_WAIT: cmd_done = read_end && rd_single;
      default:     cmd_done = 1'b0;
    endcase
  end

  assign do_next    = cmd_done && q_valid;
  assign q_pop      = do_next;
  assign timed_cmd  = do_next && (cmd_op == OP_NO_OP || cmd_op == OP_ADC_RD);
  assign start_read = do_next && (cmd_op == OP_ADC_RD || cmd_op == OP_ADC_RD_CH);
  assign next_frame = (state == S_ADC_RD || state == S_ADC_RD_CH) && frame_done;

  // Errors raised this cycle
  assign set_underflow = cmd_done && expect_next && !q_valid;
  assign set_unexp     = trigger && (state != S_TRIG_WAIT);
  assign set_short     = !wait_trig && delay_done
                         && (state == S_ADC_RD || (state == S_READ_WAIT && !rd_single && !frame_done));
  assign set_bad       = do_next && !op_known;
  assign err_now       = set_underflow || set_unexp || set_short || set_bad || data_overflow;

  //////////////////////////////////////////////////////////////////////
  // Frame issue
  //////////////////////////////////////////////////////////////////////

  assign nxt_idx     = frame_idx + 1'b1;
  assign last_idx    = rd_single ? (CH_W+1)'(1) : (CH_W+1)'(NUM_CH);
  assign frame_start = (start_read || next_frame) && !err_now;   // Back to back, no gap

  always_comb begin
    if (start_read)
      frame_ch = (cmd_op == OP_ADC_RD) ? sample_order[0] : q_word[CH_W-1:0];
    else if (nxt_idx == last_idx)
      frame_ch = '0;                                   // Dummy frame pulls the last result
    else
      frame_ch = sample_order[nxt_idx[CH_W-1:0]];
  end

  // State machine
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= S_IDLE;
    end else if (err_now) begin
      state <= S_ERROR;                                // Held until reset
    end else if (cmd_done) begin
      if (!q_valid)
        state <= S_IDLE;
      else begin
        case (cmd_op)
          OP_NO_OP:     state <= q_word[TRIG_BIT] ? S_TRIG_WAIT : S_DELAY;
          OP_SET_ORD:   state <= S_IDLE;
          OP_ADC_RD:    state <= S_ADC_RD;
          OP_ADC_RD_CH: state <= S_ADC_RD_CH;
          default:      state <= S_ERROR;
        endcase
      end
    end else if (next_frame && nxt_idx == last_idx) begin
      state <= S_READ_WAIT;
    end else if (read_end) begin
      state <= wait_trig ? S_TRIG_WAIT : S_DELAY;      // Eight-channel read finishes its wait
    end
  end

  // Command bits and frame bookkeeping
  always_ff @(posedge clk) begin
    if (!resetn) begin
      wait_trig   <= 1'b0;
      expect_next <= 1'b0;
      rd_single   <= 1'b0;
      frame_idx   <= '0;
      in_flight   <= 1'b0;
    end else begin
      if (do_next) begin
        wait_trig   <= timed_cmd && q_word[TRIG_BIT];
        expect_next <= q_word[CONT_BIT];
      end
      if (start_read) begin
        rd_single <= (cmd_op == OP_ADC_RD_CH);
        frame_idx <= '0;
      end else if (next_frame) begin
        frame_idx <= nxt_idx;
      end
      if (frame_start)
        in_flight <= 1'b1;
      else if (frame_done)
        in_flight <= 1'b0;
    end
  end

  // Delay runs from accept, trigger count only moves while waiting
  always_ff @(posedge clk) begin
    if (!resetn) begin
      delay_timer <= '0;
      trig_cnt    <= '0;
    end else begin
      if (timed_cmd && !q_word[TRIG_BIT])
        delay_timer <= q_word[COUNT_W-1:0];
      else if (!delay_done)
        delay_timer <= delay_timer - 1'b1;
      if (timed_cmd && q_word[TRIG_BIT])
        trig_cnt <= q_word[COUNT_W-1:0];
      else if (state == S_TRIG_WAIT && trigger && trig_cnt != '0)
        trig_cnt <= trig_cnt - 1'b1;
    end
  end

  // Sample order table, identity out of reset
  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < NUM_CH; i++)
        sample_order[i] <= CH_W'(i);
    end else if (do_next && cmd_op == OP_SET_ORD) begin
      for (int i = 0; i < NUM_CH; i++)
        sample_order[i] <= q_word[i*CH_W +: CH_W];
    end
  end

  // Sticky error flags
  always_ff @(posedge clk) begin
    if (!resetn) begin
      cmd_underflow   <= 1'b0;
      unexp_trig      <= 1'b0;
      delay_too_short <= 1'b0;
      bad_cmd         <= 1'b0;
    end else begin
      if (set_underflow) cmd_underflow <= 1'b1;
      if (set_unexp)     unexp_trig <= 1'b1;
      if (set_short)     delay_too_short <= 1'b1;
      if (set_bad)       bad_cmd <= 1'b1;
    end
  end

  // First frame of a read returns stale data
  assign sample_valid     = rx_valid && (frame_idx != '0)
                            && (state inside {S_ADC_RD, S_ADC_RD_CH, S_READ_WAIT});
  assign sample_word      = rx_word;
  assign sample_single    = rd_single;
  assign waiting_for_trig = (state == S_TRIG_WAIT);

  // Next frame only once the engine is free
  a_one_frame: assert property (@(posedge clk) disable iff (!resetn)
    frame_start |-> !in_flight || frame_done);

endmodule

// ==== adc_cmd_queue.sv ====
`timescale 1ns/1ps

module adc_cmd_queue import adc_ctrl_pkg::*; (
  input  logic             clk,
  input  logic             resetn,
  input  logic             cmd_valid,    // Host write, only while it holds a credit
  input  logic [CMD_W-1:0] cmd_word,
  input  logic             q_pop,
  output logic [CMD_W-1:0] q_word,
  output logic             q_valid,
  output logic             cmd_credit    // One pulse per popped entry
);

  logic [CMD_W-1:0]               mem [CMD_DEPTH];
  logic [$clog2(CMD_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(CMD_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(CMD_DEPTH+1)-1:0] count;
  logic                           push;
  logic                           pop;

  assign push = cmd_valid && (count != CMD_DEPTH);
  assign pop  = q_pop && q_valid;

  // Entry storage
  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= cmd_word;
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (!resetn) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      cmd_credit <= 1'b0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
      cmd_credit <= pop;   // Freed slot goes back to the host
    end
  end

  assign q_word  = mem[rd_ptr];
  assign q_valid = (count != '0);

  // Host never writes past its credits
  a_no_write_full: assert property (@(posedge clk) disable iff (!resetn)
    cmd_valid |-> count < CMD_DEPTH);

endmodule

// ==== adc_ctrl_pkg.sv ====
package adc_ctrl_pkg;

  //////////////////////////////////////////////////////////////////////
  // Word and channel sizes
  //////////////////////////////////////////////////////////////////////

  localparam int CMD_W    = 32;   // Command and data word
  localparam int SAMPLE_W = 16;   // One ADC sample, one SPI frame
  localparam int NUM_CH   = 8;
  localparam int CH_W     = 3;
  localparam int COUNT_W  = 25;   // Delay cycles or trigger count field

  // SPI timing
  localparam int CS_HIGH_CYCLES = 8;                        // n_cs high gap before a frame
  localparam int CS_CNT_W       = $clog2(CS_HIGH_CYCLES);

  // Host flow control
  localparam int CMD_DEPTH    = 4;    // Also the host's starting credit count
  localparam int DATA_CREDITS = 4;
  localparam int CRED_W       = $clog2(DATA_CREDITS + 1);

  //////////////////////////////////////////////////////////////////////
  // Command layout
  //////////////////////////////////////////////////////////////////////

  localparam int OP_LSB   = 29;   // Opcode sits in bits 31..29
  localparam int TRIG_BIT = 28;   // Wait on trigger count, not delay
  localparam int CONT_BIT = 27;   // Another command must follow

  typedef enum logic [2:0] {
    OP_NO_OP     = 3'd0,   // Delay or trigger wait only
    OP_SET_ORD   = 3'd1,   // Load eight 3-bit channel slots
    OP_ADC_RD    = 3'd2,   // Read all eight channels in sample order
    OP_ADC_RD_CH = 3'd3    // Read one channel
  } cmd_op_e;

  // Sequencer states
  typedef enum logic [3:0] {
    S_IDLE,
    S_DELAY,
    S_TRIG_WAIT,
    S_ADC_RD,
    S_ADC_RD_CH,
    S_READ_WAIT,   // Last frame in flight
    S_ERROR
  } seq_state_e;

  // On-the-fly sample request is prefix, channel, then zero padding
  localparam logic [1:0] OTF_REQ_PREFIX = 2'b10;
  localparam int         OTF_PAD_W      = SAMPLE_W - 2 - CH_W;

endpackage
